// ==== logic/membuf_cfg.svh ====
`ifndef MEMBUF_CFG_SVH
`define MEMBUF_CFG_SVH

// Data and address width
`define MEMBUF_XLEN 32

// Pending requests held by the buffer
`define MEMBUF_DEPTH 2

// Data memory size in words
`define MEM_WORDS 64

// Busy cycles after each accepted access
`define MEM_WAIT 2

`endif

// ==== logic/biu_pkg.sv ====
package biu_pkg;

  //////////////////////////////
  // Access size
  //////////////////////////////

  // Encoded transfer width, aligned accesses only
  typedef enum logic [1:0] {
    BIU_BYTE = 2'b00,
    BIU_HALF = 2'b01,
    BIU_WORD = 2'b10
  } biu_size_t;

  //////////////////////////////
  // Protection
  //////////////////////////////

  // Bit 1 data/instruction, bit 0 privileged/user
  typedef struct packed {
    logic data;
    logic privileged;
  } biu_prot_t;

  // Common attribute values
  localparam biu_prot_t BIU_PROT_USER_DATA = '{data: 1'b1, privileged: 1'b0};
  localparam biu_prot_t BIU_PROT_PRIV_DATA = '{data: 1'b1, privileged: 1'b1};

endpackage

// ==== logic/mem_data_pkg.sv ====
`include "membuf_cfg.svh"

package mem_data_pkg;

  import biu_pkg::*;

  //////////////////////////////
  // Memory word
  //////////////////////////////

  // Same word seen whole or as byte lanes
  typedef union packed {
    logic [`MEMBUF_XLEN-1:0]        word;
    logic [`MEMBUF_XLEN/8-1:0][7:0] lanes;
  } mem_word_u;

  //////////////////////////////
  // Queue entry
  //////////////////////////////

  // One pending request, 2*XLEN+5 bits
  typedef struct packed {
    logic [`MEMBUF_XLEN-1:0] adr;
    biu_size_t               size;
    biu_prot_t               prot;
    logic                    we;
    logic [`MEMBUF_XLEN-1:0] d;
  } mem_entry_t;

endpackage

// ==== logic/access_queue.sv ====
`timescale 1ns/1ns

module access_queue #(
  parameter int DEPTH = 2,
  parameter int DBITS = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clr_i,
  input  logic             we_i,
  input  logic [DBITS-1:0] d_i,
  input  logic             re_i,
  output logic [DBITS-1:0] q_o,
  output logic             empty_o,
  output logic             full_o
);

  // Pointer and fill count widths
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [DBITS-1:0] mem_q [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    cnt;
  logic             do_wr;
  logic             do_rd;

  // Wrap at DEPTH, also for non power of two sizes
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Read only when something is there
  assign do_rd = re_i & ~empty_o;
  // A full queue still takes a write when the head leaves
  assign do_wr = we_i & (~full_o | do_rd);

  //////////////////////////////
  // Pointers and fill count
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else if (clr_i) begin
      // Drop everything in one cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_q[wr_ptr] <= d_i;
    end
  end

  // Head is visible without a read
  assign q_o     = mem_q[rd_ptr];
  assign empty_o = (cnt == '0);
  assign full_o  = (cnt == CW'(DEPTH));

endmodule

// ==== logic/access_buffer.sv ====
`timescale 1ns/1ns
`include "membuf_cfg.svh"

module access_buffer
  import biu_pkg::*;
  import mem_data_pkg::*;
#(
  parameter int DEPTH = `MEMBUF_DEPTH
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    stall_i,
  // CPU side
  input  logic                    req_i,
  input  logic [`MEMBUF_XLEN-1:0] adr_i,
  input  biu_size_t               size_i,
  input  biu_prot_t               prot_i,
  input  logic                    we_i,
  input  logic [`MEMBUF_XLEN-1:0] d_i,
  // Memory side
  output logic                    req_o,
  output logic [`MEMBUF_XLEN-1:0] adr_o,
  output biu_size_t               size_o,
  output biu_prot_t               prot_o,
  output logic                    we_o,
  output logic [`MEMBUF_XLEN-1:0] q_o,
  // Queue state
  output logic                    empty_o,
  output logic                    full_o
);

  mem_entry_t             queue_d;
  mem_entry_t             queue_q;
  logic                   queue_we;
  logic                   queue_re;
  logic [$clog2(DEPTH):0] access_pending;

  //////////////////////////////
  // Request queue
  //////////////////////////////

  // Pack live request
  assign queue_d.adr  = adr_i;
  assign queue_d.size = size_i;
  assign queue_d.prot = prot_i;
  assign queue_d.we   = we_i;
  assign queue_d.d    = d_i;

  access_queue #(
    .DEPTH (DEPTH),
    .DBITS ($bits(mem_entry_t))
  ) u_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clr_i   (flush_i),
    .we_i    (queue_we),
    .d_i     (queue_d),
    .re_i    (queue_re),
    .q_o     (queue_q),
    .empty_o (empty_o),
    .full_o  (full_o)
  );

  //////////////////////////////
  // Pending count
  //////////////////////////////

  // Up on request without a free slot, down on a free slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      access_pending <= '0;
    end else if (flush_i) begin
      access_pending <= '0;
    end else begin
      case ({req_i, ~stall_i})
        2'b01:   access_pending <= |access_pending ? access_pending - 1'b1 : '0;
        2'b10:   access_pending <= access_pending + 1'b1;
        default: access_pending <= access_pending;
      endcase
    end
  end

  // Queue when stalled or when older requests wait
  assign queue_we = req_i & (stall_i | |access_pending);
  // Head leaves when the memory is free
  assign queue_re = ~empty_o & ~stall_i;

  // Head first, live request only on an empty queue
  assign req_o  = ~empty_o | req_i;
  assign adr_o  = empty_o ? adr_i  : queue_q.adr;
  assign size_o = empty_o ? size_i : queue_q.size;
  assign prot_o = empty_o ? prot_i : queue_q.prot;
  assign we_o   = empty_o ? we_i   : queue_q.we;
  assign q_o    = empty_o ? d_i    : queue_q.d;

endmodule

// ==== logic/data_memory.sv ====
`timescale 1ns/1ns
`include "membuf_cfg.svh"

module data_memory
  import biu_pkg::*;
  import mem_data_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic [`MEMBUF_XLEN-1:0] adr_i,
  input  biu_size_t               size_i,
  input  biu_prot_t               prot_i,
  input  logic                    we_i,
  input  logic [`MEMBUF_XLEN-1:0] wdata_i,
  output logic                    ready_o,
  output logic [`MEMBUF_XLEN-1:0] rdata_o,
  output logic                    rvalid_o,
  output logic                    err_o
);

  // Lanes per word, byte offset bits, word index bits
  localparam int LANES = `MEMBUF_XLEN / 8;
  localparam int OFS   = $clog2(LANES);
  localparam int IW    = $clog2(`MEM_WORDS);
  localparam int WW    = $clog2(`MEM_WAIT + 1);

  mem_word_u     mem_q [`MEM_WORDS];
  mem_word_u     wr_word;
  logic [IW-1:0] idx;
  logic [OFS-1:0] ofs;
  logic [LANES-1:0] lane_en;
  logic [WW-1:0] wait_cnt;
  logic          accept;
  logic          prot_fail;

  // Word index and lane offset
  assign idx = adr_i[OFS +: IW];
  assign ofs = adr_i[OFS-1:0];

  //////////////////////////////
  // Wait states
  //////////////////////////////

  assign ready_o = (wait_cnt == '0);
  assign accept  = req_i & ready_o;

  // Reload on accept, count down to ready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_cnt <= '0;
    end else if (accept) begin
      wait_cnt <= WW'(`MEM_WAIT);
    end else if (wait_cnt != '0) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  // User access to upper half of memory
  assign prot_fail = adr_i[OFS+IW-1] & ~prot_i.privileged;

  //////////////////////////////
  // Lane merge
  //////////////////////////////

  always_comb begin
    wr_word = mem_q[idx];
    for (int i = 0; i < LANES; i++) begin
      case (size_i)
        BIU_BYTE: lane_en[i] = (i == int'(ofs));
        BIU_HALF: lane_en[i] = ((i / 2) == (int'(ofs) / 2));
        BIU_WORD: lane_en[i] = 1'b1;
        default:  lane_en[i] = 1'b0;
      endcase
      // Narrow data sits in the low bits of wdata_i
      if (lane_en[i]) begin
        case (size_i)
          BIU_BYTE: wr_word.lanes[i] = wdata_i[7:0];
          BIU_HALF: wr_word.lanes[i] = wdata_i[8*(i%2) +: 8];
          default:  wr_word.lanes[i] = wdata_i[8*i +: 8];
        endcase
      end
    end
  end

  // Array write, blocked on a protection fault
  always_ff @(posedge clk_i) begin
    if (accept && we_i && !prot_fail) begin
      mem_q[idx] <= wr_word;
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  // Read data, zero when the access faults
  always_ff @(posedge clk_i) begin
    if (accept && !we_i) begin
      rdata_o <= prot_fail ? '0 : mem_q[idx].word;
    end
  end

  // One cycle pulses after the accept
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      rvalid_o <= accept & ~we_i;
      err_o    <= accept & prot_fail;
    end
  end

endmodule

// ==== logic/mem_subsys_top.sv ====
`timescale 1ns/1ns
`include "membuf_cfg.svh"

module mem_subsys_top
  import biu_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  // CPU request
  input  logic                    req_i,
  input  logic [`MEMBUF_XLEN-1:0] adr_i,
  input  biu_size_t               size_i,
  input  biu_prot_t               prot_i,
  input  logic                    we_i,
  input  logic [`MEMBUF_XLEN-1:0] wdata_i,
  output logic                    full_o,
  output logic                    empty_o,
  // Read response and fault
  output logic [`MEMBUF_XLEN-1:0] rdata_o,
  output logic                    rvalid_o,
  output logic                    err_o
);

  // Buffer to memory
  logic                    mem_req;
  logic [`MEMBUF_XLEN-1:0] mem_adr;
  biu_size_t               mem_size;
  biu_prot_t               mem_prot;
  logic                    mem_we;
  logic [`MEMBUF_XLEN-1:0] mem_wdata;
  logic                    mem_ready;
  logic                    mem_stall;

  // Busy memory stalls the buffer
  assign mem_stall = ~mem_ready;

  access_buffer #(
    .DEPTH (`MEMBUF_DEPTH)
  ) u_buffer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .stall_i (mem_stall),
    .req_i   (req_i),
    .adr_i   (adr_i),
    .size_i  (size_i),
    .prot_i  (prot_i),
    .we_i    (we_i),
    .d_i     (wdata_i),
    .req_o   (mem_req),
    .adr_o   (mem_adr),
    .size_o  (mem_size),
    .prot_o  (mem_prot),
    .we_o    (mem_we),
    .q_o     (mem_wdata),
    .empty_o (empty_o),
    .full_o  (full_o)
  );

  data_memory u_memory (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (mem_req),
    .adr_i    (mem_adr),
    .size_i   (mem_size),
    .prot_i   (mem_prot),
    .we_i     (mem_we),
    .wdata_i  (mem_wdata),
    .ready_o  (mem_ready),
    .rdata_o  (rdata_o),
    .rvalid_o (rvalid_o),
    .err_o    (err_o)
  );

endmodule

// ==== verification/tb_mem_subsys_assert.sv ====
`timescale 1ns/1ns
`include "membuf_cfg.svh"

module tb_mem_subsys_assert
  import biu_pkg::*;
  import mem_data_pkg::*;
(
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    flush_i,
  input logic                    req_i,
  input logic [`MEMBUF_XLEN-1:0] adr_i,
  input biu_size_t               size_i,
  input biu_prot_t               prot_i,
  input logic                    we_i,
  input logic [`MEMBUF_XLEN-1:0] wdata_i,
  input logic                    mem_req,
  input logic                    mem_ready,
  input logic [`MEMBUF_XLEN-1:0] mem_adr,
  input logic                    mem_we,
  input logic [`MEMBUF_XLEN-1:0] mem_wdata,
  input logic [`MEMBUF_XLEN-1:0] rdata_o,
  input logic                    rvalid_o,
  input logic                    err_o
);

  // Byte address bits and lane offset bits
  localparam int AB  = $clog2(`MEM_WORDS * (`MEMBUF_XLEN / 8));
  localparam int OFS = $clog2(`MEMBUF_XLEN / 8);

  mem_entry_t              issued_q [$];
  mem_entry_t              head;
  mem_entry_t              live;
  logic [7:0]              shadow [`MEM_WORDS * (`MEMBUF_XLEN / 8)];
  mem_word_u               exp_word;
  logic [AB-1:0]           ba;
  logic                    queued;
  logic                    has_head;
  logic                    bypass;
  logic                    head_ok;
  logic                    accept;
  logic                    prot_hit;
  logic                    exp_rvalid;
  logic                    exp_err;
  logic [`MEMBUF_XLEN-1:0] exp_rdata;
  int                      fail_cnt = 0;

  assign accept = mem_req & mem_ready;

  //////////////////////////////
  // Oldest issued request
  //////////////////////////////

  always_comb begin
    live     = '{adr: adr_i, size: size_i, prot: prot_i, we: we_i, d: wdata_i};
    queued   = (issued_q.size() > 0);
    // Nothing older waiting, so the live request is the head
    has_head = queued | req_i;
    head     = queued ? issued_q[0] : live;
    bypass   = ~queued & req_i & accept;
    ba       = head.adr[AB-1:0];
    // User mode in the upper half
    prot_hit = ba[AB-1] & ~head.prot.privileged;
    head_ok  = has_head && (head.adr == mem_adr) && (head.we == mem_we) &&
               (!mem_we || (head.d == mem_wdata));
    for (int i = 0; i < `MEMBUF_XLEN / 8; i++) begin
      exp_word.lanes[i] = shadow[{ba[AB-1:OFS], OFS'(i)}];
    end
  end

  // Retire in order at accept, log at issue, drop on flush
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_rvalid <= 1'b0;
      exp_err    <= 1'b0;
      issued_q.delete();
    end else begin
      exp_rvalid <= accept & has_head & ~head.we;
      exp_err    <= accept & has_head & prot_hit;
      if (accept && !head.we) begin
        exp_rdata <= prot_hit ? '0 : exp_word.word;
      end
      if (accept && has_head && head.we && !prot_hit) begin
        case (head.size)
          BIU_BYTE: shadow[ba] <= head.d[7:0];
          BIU_HALF: begin
            shadow[{ba[AB-1:1], 1'b0}] <= head.d[7:0];
            shadow[{ba[AB-1:1], 1'b1}] <= head.d[15:8];
          end
          default: begin
            for (int i = 0; i < `MEMBUF_XLEN / 8; i++) begin
              shadow[{ba[AB-1:OFS], OFS'(i)}] <= head.d[8*i +: 8];
            end
          end
        endcase
      end
      if (accept && queued) begin
        void'(issued_q.pop_front());
      end
      // A bypassed request retires in the cycle it is issued
      if (flush_i) begin
        issued_q.delete();
      end else if (req_i && !bypass) begin
        issued_q.push_back(live);
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_order: assert property (@(posedge clk_i) disable iff (!rst_ni) accept |-> head_ok)
    else begin
      $error("memory accepted a request out of issue order");
      fail_cnt++;
    end

  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_o == exp_rvalid)
    else begin
      $error("rvalid_o does not follow the read accept");
      fail_cnt++;
    end

  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
                            rvalid_o |-> rdata_o == exp_rdata)
    else begin
      $error("read data differs from the shadow memory");
      fail_cnt++;
    end

  a_err: assert property (@(posedge clk_i) disable iff (!rst_ni) err_o == exp_err)
    else begin
      $error("err_o does not match the protection rule");
      fail_cnt++;
    end

  // Stalled head keeps its address and data until accepted
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
                           mem_req && !mem_ready && !flush_i |=>
                           mem_req && $stable(mem_adr) && $stable(mem_we) &&
                           $stable(mem_wdata))
    else begin
      $error("stalled request changed before the memory accepted it");
      fail_cnt++;
    end

endmodule

// ==== verification/tb_mem_subsys.sv ====
`timescale 1ns/1ns
`include "membuf_cfg.svh"

module tb_mem_subsys
  import biu_pkg::*;
;

  localparam int TIMEOUT = 200;

  logic                    clk;
  logic                    rst_n;
  logic                    flush;
  logic                    req;
  logic [`MEMBUF_XLEN-1:0] adr;
  biu_size_t               size;
  biu_prot_t               prot;
  logic                    we;
  logic [`MEMBUF_XLEN-1:0] wdata;
  logic                    full;
  logic                    empty;
  logic [`MEMBUF_XLEN-1:0] rdata;
  logic                    rvalid;
  logic                    err;
  int                      err_cnt;
  int                      timeout_cnt;
  int                      total;

  // 100 ns clock
  always #50 clk = ~clk;

  mem_subsys_top UUT (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .flush_i  (flush),
    .req_i    (req),
    .adr_i    (adr),
    .size_i   (size),
    .prot_i   (prot),
    .we_i     (we),
    .wdata_i  (wdata),
    .full_o   (full),
    .empty_o  (empty),
    .rdata_o  (rdata),
    .rvalid_o (rvalid),
    .err_o    (err)
  );

  bind mem_subsys_top tb_mem_subsys_assert u_check (
    .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i), .req_i (req_i),
    .adr_i (adr_i), .size_i (size_i), .prot_i (prot_i), .we_i (we_i),
    .wdata_i (wdata_i), .mem_req (mem_req),
    .mem_ready (mem_ready), .mem_adr (mem_adr), .mem_we (mem_we),
    .mem_wdata (mem_wdata), .rdata_o (rdata_o), .rvalid_o (rvalid_o), .err_o (err_o)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  // Called on a falling edge; holds off while full
  task automatic issue(input logic [31:0] a, input biu_size_t sz, input biu_prot_t pr,
                       input logic w, input logic [31:0] d);
    int n;
    n = 0;
    while (full && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (full) begin
      $display("Timeout: full_o never dropped before issuing a request");
      timeout_cnt++;
    end
    req   = 1'b1;
    adr   = a;
    size  = sz;
    prot  = pr;
    we    = w;
    wdata = d;
    @(negedge clk);
    req = 1'b0;
  endtask

  // Queue drained and memory free
  task automatic wait_idle();
    int n;
    n = 0;
    while (!(empty && UUT.mem_ready && !rvalid) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (n >= TIMEOUT) begin
      $display("Timeout: buffer and memory did not become idle");
      timeout_cnt++;
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int i;
    void'($urandom(32'hd7c4));
    clk = 1'b0;
    rst_n = 1'b0;
    flush = 1'b0;
    req = 1'b0;
    we = 1'b0;
    adr = '0;
    wdata = '0;
    size = BIU_WORD;
    prot = BIU_PROT_PRIV_DATA;
    err_cnt = 0;
    timeout_cnt = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset_empty", 32'd1, 32'(empty));
    check_value("reset_full", 32'd0, 32'(full));
    check_value("reset_rvalid", 32'd0, 32'(rvalid));
    check_value("reset_err", 32'd0, 32'(err));

    // Known contents for the lower words
    for (i = 0; i < 24; i++) begin
      issue(32'(i * 4), BIU_WORD, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    end
    wait_idle();

    // Narrow writes then read back merged words
    issue(32'h02, BIU_HALF, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    issue(32'h05, BIU_BYTE, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    issue(32'h07, BIU_BYTE, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    issue(32'h08, BIU_HALF, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    for (i = 0; i < 3; i++) begin
      issue(32'(i * 4), BIU_WORD, BIU_PROT_PRIV_DATA, 1'b0, '0);
    end
    wait_idle();

    // Mixed traffic back to back and served in order
    issue(32'h0c, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    issue(32'h0c, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b0, '0);
    issue(32'h0d, BIU_BYTE, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    issue(32'h10, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b0, '0);
    issue(32'h0c, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b0, '0);
    wait_idle();

    // Fill the queue during the wait states
    for (i = 0; i < `MEMBUF_DEPTH + 1; i++) begin
      issue(32'h20 + 32'(i * 4), BIU_WORD, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    end
    check_value("backpressure_full", 32'd1, 32'(full));
    for (i = 0; i < `MEMBUF_DEPTH + 1; i++) begin
      issue(32'h20 + 32'(i * 4), BIU_WORD, BIU_PROT_PRIV_DATA, 1'b0, '0);
    end
    wait_idle();

    // Head leaves on the flush edge and the tail write to word 12 is dropped
    issue(32'h50, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    issue(32'h54, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    issue(32'h30, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    check_value("flush_empty", 32'd1, 32'(empty));
    wait_idle();
    issue(32'h30, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b0, '0);
    wait_idle();

    // User access to the upper half faults while privileged access works
    issue(32'hc0, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    wait_idle();
    issue(32'hc0, BIU_WORD, BIU_PROT_USER_DATA, 1'b1, $urandom());
    check_value("prot_user_write_err", 32'd1, 32'(err));
    wait_idle();
    issue(32'hc0, BIU_WORD, BIU_PROT_USER_DATA, 1'b0, '0);
    check_value("prot_user_read_err", 32'd1, 32'(err));
    wait_idle();
    issue(32'hc0, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b0, '0);
    wait_idle();
    issue(32'hc0, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b1, $urandom());
    check_value("prot_priv_write_err", 32'd0, 32'(err));
    wait_idle();
    issue(32'hc0, BIU_WORD, BIU_PROT_PRIV_DATA, 1'b0, '0);
    wait_idle();
    @(negedge clk);

    total = err_cnt + timeout_cnt + UUT.u_check.fail_cnt;
    $display("Done: %0d errors, %0d timeouts, %0d assertion failures",
             err_cnt, timeout_cnt, UUT.u_check.fail_cnt);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== mem_subsys.f ====
+incdir+logic
logic/biu_pkg.sv
logic/mem_data_pkg.sv
logic/access_queue.sv
logic/access_buffer.sv
logic/data_memory.sv
logic/mem_subsys_top.sv
verification/tb_mem_subsys_assert.sv
verification/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f mem_subsys.f --top-module tb_mem_subsys -o sim_tb \
  && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "Build or run aborted" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
